// File: dv/pm_sva.sv
// Strobe and cycle-start checks
`timescale 1ns/1ps

module pm_sva
	import pm_pkg::*;
(
	input logic        clk_sys,
	input logic        M95_10,
	input logic        strob1,
	input logic        strob1b,
	input logic        strob2,
	input logic        strob2b,
	input logic        pc,
	input cycle_kind_t kind,
	input logic        sp0,
	input logic        sp1,
	input logic        si1
);

	// Cycle start belongs to the first phase, the others follow in order
	a_pc_with_strob1: assert property (
		@(posedge clk_sys) disable iff (!M95_10)
			pc |-> strob1 ##1 strob1b ##1 strob2 ##1 strob2b
	) else $error("Cycle after pc did not run strob1, strob1b, strob2, strob2b in order");

	// Phase strobes only while a cycle kind is chosen
	a_strobes_in_cycle: assert property (
		@(posedge clk_sys) disable iff (!M95_10)
			(strob1 | strob1b | strob2 | strob2b) |-> (kind != CK_NONE)
	) else $error("Phase strobe active with no cycle in progress");

	// A cycle has exactly one kind
	a_start_onehot: assert property (
		@(posedge clk_sys) disable iff (!M95_10) pc |-> $onehot({sp0, sp1, si1})
	) else $error("Cycle start without exactly one of sp0, sp1, si1");

endmodule : pm_sva

bind run_ctl pm_sva i_sva (
	.clk_sys (clk_sys),
	.M95_10  (M95_10),
	.strob1  (stb.strob1),
	.strob1b (stb.strob1b),
	.strob2  (stb.strob2),
	.strob2b (stb.strob2b),
	.pc      (stb.pc),
	.kind    (kind),
	.sp0     (sp0),
	.sp1     (sp1),
	.si1     (si1)
);

// File: dv/pm_tb.sv
// P-M control testbench
`timescale 1ns/1ps

module pm_tb
	import pm_pkg::*;
();

	localparam int CLK_PERIOD_NS = 20;
	localparam int N_ROWS        = 16;
	localparam int ROW_CLKS_MAX  = 40;
	localparam int WAIT_LIMIT    = 24;
	localparam int TIMEOUT_NS    = (N_ROWS * ROW_CLKS_MAX + 8) * CLK_PERIOD_NS;

	// Output selectors for the wait helpers
	localparam int SIG_SP1  = 0;
	localparam int SIG_SP0  = 1;
	localparam int SIG_WAIT = 2;
	localparam int SIG_ANY  = 3;

	typedef enum int {A_IDLE, A_START, A_STOP, A_CYCLE, A_HLT, A_MD, A_IRQ, A_PANEL} act_t;

	typedef struct packed {
		act_t act;
		int   arg;
		int   cnt;
		logic exp_run;
		int   exp_mc;
	} row_t;

	logic            clk_sys;
	logic            M95_10;
	logic            start;
	logic            stop;
	logic            clo;
	logic            hlt;
	logic            cycle;
	logic            irq;
	logic            panel_store;
	logic            panel_fetch;
	logic            panel_load;
	logic            md;
	logic            gr;
	logic [2:0]      ir_grp;
	logic [LK_W-1:0] shift_cnt;
	logic            run;
	logic            waiting;
	logic            sp0;
	logic            sp1;
	logic            si1;
	logic            laduj;
	logic            k2fetch;
	logic            k2store;
	logic            mc_0;
	logic            mc_3;
	logic [LG_W-1:0] lg;
	logic [LK_W-1:0] lk;
	logic            lk_zero;

	// Expected counter state, updated per completed cycle
	logic [LG_W-1:0] lg_exp;
	logic [LK_W-1:0] lk_exp;
	logic [31:0]     lfsr_q;
	int              errors;
	int              checks;

	// Action, argument, wait count, run, MC
	row_t rows [N_ROWS] = '{
		'{A_IDLE,  0, 10, 1'b0, 0},
		'{A_START, 0, 3,  1'b1, 0},
		'{A_STOP,  0, 12, 1'b0, 0},
		'{A_CYCLE, 0, 12, 1'b0, 0},
		'{A_START, 0, 2,  1'b1, 0},
		'{A_HLT,   0, 0,  1'b0, 0},
		'{A_IRQ,   1, 2,  1'b1, 0},
		'{A_MD,    1, 4,  1'b1, 3},
		'{A_IRQ,   0, 0,  1'b1, 3},
		'{A_MD,    0, 0,  1'b1, 3},
		'{A_IRQ,   1, 2,  1'b1, 0},
		'{A_STOP,  0, 12, 1'b0, 0},
		'{A_PANEL, 0, 4,  1'b0, 0},
		'{A_PANEL, 1, 4,  1'b0, 0},
		'{A_MD,    2, 0,  1'b0, 0},
		'{A_PANEL, 2, 4,  1'b0, 0}
	};

	pm_top i_dut (.*);

	always #(CLK_PERIOD_NS / 2) clk_sys = ~clk_sys;

	// Taps 32, 22, 2, 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic logic [3:0] rand_bits(input int n);
		logic [3:0] v;
		v = '0;
		for (int b = 0; b < n; b++) v = {v[2:0], lfsr_step()};
		return v;
	endfunction

	function automatic logic watched(input int sel);
		case (sel)
			SIG_SP1:  return sp1;
			SIG_SP0:  return sp0;
			SIG_WAIT: return waiting;
			default:  return sp0 | sp1 | si1;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_for(input int sel, input string what, output int clks);
		clks = 0;
		do begin
			@(negedge clk_sys);
			clks++;
		end while (!watched(sel) && clks < WAIT_LIMIT);
		if (!watched(sel)) begin
			$display("Timed out waiting for %s", what);
			errors++;
		end
	endtask

	task automatic count_in_window(input int sel, input int clks, output int n);
		n = 0;
		repeat (clks) begin
			@(negedge clk_sys);
			if (watched(sel)) n++;
		end
	endtask

	task automatic pulse_input(input act_t act, input int arg);
		case (act)
			A_START: start = 1'b1;
			A_STOP:  stop = 1'b1;
			A_CYCLE: cycle = 1'b1;
			A_HLT:   hlt = 1'b1;
			A_PANEL: begin
				panel_store = (arg == 0);
				panel_fetch = (arg == 1);
				panel_load  = (arg == 2);
			end
			default: ;
		endcase
		@(negedge clk_sys);
		{start, stop, cycle, hlt, panel_store, panel_fetch, panel_load} = '0;
	endtask

	// A fetch cycle reloads LG and LK at strob2
	task automatic fetch_done();
		if (gr) lg_exp = ir_grp[LG_W-1:0];
		lk_exp = shift_cnt;
	endtask

	// Panel and interrupt cycles only step the counters
	task automatic other_done();
		if (gr) lg_exp = lg_exp + LG_W'(1);
		if (lk_exp != 0) lk_exp = lk_exp - LK_W'(1);
	endtask

	task automatic apply_row(input row_t r);
		int gap;
		int n;
		int d;
		case (r.act)
			A_IDLE: begin
				count_in_window(SIG_ANY, r.cnt, n);
				check_val("start_strobes", n, 0);
				check_val("waiting", 32'(waiting), 0);
				check_val("panel_flags", 32'({laduj, k2fetch, k2store}), 0);
			end
			A_START: begin
				pulse_input(r.act, r.arg);
				wait_for(SIG_SP1, "sp1", gap);
				for (int k = 1; k < r.cnt; k++) begin
					wait_for(SIG_SP1, "sp1", gap);
					check_val("sp1_spacing", gap, 4);
				end
				if (r.cnt >= 2) fetch_done();
			end
			A_STOP: begin
				pulse_input(r.act, r.arg);
				count_in_window(SIG_ANY, r.cnt, n);
				check_val("cycles_after_stop", n, 0);
				fetch_done();
			end
			A_CYCLE: begin
				shift_cnt = rand_bits(2);
				pulse_input(r.act, r.arg);
				count_in_window(SIG_SP1, r.cnt, n);
				check_val("single_cycle_sp1", n, 1);
				fetch_done();
			end
			A_HLT: begin
				pulse_input(r.act, r.arg);
				wait_for(SIG_WAIT, "waiting after hlt", gap);
				fetch_done();
			end
			A_MD: begin
				// Bit 0 drives md, bit 1 drops gr
				md = r.arg[0];
				gr = !r.arg[1];
				repeat (r.cnt) wait_for(SIG_SP1, "sp1", gap);
				if (r.cnt >= 2) fetch_done();
			end
			A_IRQ: begin
				if (!irq) begin
					d = int'(rand_bits(3));
					repeat (d) @(negedge clk_sys);
					irq = 1'b1;
				end
				wait_for(SIG_ANY, "sp1 or si1", gap);
				check_val("si1", 32'(si1), 32'(r.arg));
				if (si1) begin
					irq = 1'b0;
					other_done();
				end else begin
					fetch_done();
				end
				repeat (r.cnt) wait_for(SIG_SP1, "sp1", gap);
				if (r.cnt >= 2) fetch_done();
				check_val("waiting", 32'(waiting), 0);
			end
			default: begin
				pulse_input(r.act, r.arg);
				wait_for(SIG_SP0, "sp0", gap);
				check_val("k2store", 32'(k2store), 32'(r.arg == 0));
				check_val("k2fetch", 32'(k2fetch), 32'(r.arg == 1));
				check_val("laduj", 32'(laduj), 32'(r.arg == 2));
				other_done();
				repeat (r.cnt) @(negedge clk_sys);
				check_val("panel_flags", 32'({laduj, k2fetch, k2store}), 0);
			end
		endcase
	endtask

	task automatic check_row(input row_t r);
		check_val("run", 32'(run), 32'(r.exp_run));
		check_val("mc_0", 32'(mc_0), 32'(r.exp_mc == 0));
		check_val("mc_3", 32'(mc_3), 32'(r.exp_mc == MC_LAST));
		check_val("lg", 32'(lg), 32'(lg_exp));
		check_val("lk", 32'(lk), 32'(lk_exp));
		check_val("lk_zero", 32'(lk_zero), 32'(lk_exp == 0));
	endtask

	initial begin
		clk_sys = 1'b0;
		M95_10 = 1'b0;
		{start, stop, clo, hlt, cycle, irq} = '0;
		{panel_store, panel_fetch, panel_load, md} = '0;
		gr = 1'b1;
		ir_grp = 3'b110;
		shift_cnt = '0;
		lg_exp = '0;
		lk_exp = '0;
		lfsr_q = 32'h2665;
		errors = 0;
		checks = 0;
		repeat (8) @(negedge clk_sys);
		M95_10 = 1'b1;
		for (int i = 0; i < N_ROWS; i++) begin
			apply_row(rows[i]);
			check_row(rows[i]);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Bound from the table length and the longest row
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the stimulus table finished");
		$display("Regression failed");
		$finish;
	end

endmodule : pm_tb

// File: pm_top.f
source/pm_pkg.sv
source/pm_strobe_if.sv
source/strobe_gen.sv
source/run_ctl.sv
source/panel_regs.sv
source/seq_counters.sv
source/pm_top.sv
dv/pm_sva.sv
dv/pm_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the P-M testbench with Verilator, run it and scan the log for the result
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module pm_tb \
	-f pm_top.f \
	-o pm_sim

./obj_dir/pm_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
	echo "Simulation result: PASS"
else
	echo "Simulation result: FAIL"
	exit 1
fi

// File: source/panel_regs.sv
// Control panel request flags
`timescale 1ns/1ps

module panel_regs
	import pm_pkg::*;
(
	input  logic        clk_sys,
	input  logic        M95_10,
	input  logic        clo,
	input  logic        panel_store,
	input  logic        panel_fetch,
	input  logic        panel_load,
	input  cycle_kind_t kind,
	pm_strobe_if.user   stb,
	output logic        panel_req,
	output logic        laduj,
	output logic        k2fetch,
	output logic        k2store
);

	// Bit 2 load, bit 1 fetch, bit 0 store
	logic [2:0] flags;
	logic       in_panel;
	logic       served;

	assign in_panel = (kind == CK_PANEL);
	// Request is done once its panel cycle reaches strob2
	assign served   = in_panel & stb.strob2;

	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			flags <= 3'b000;
		end else if (clo) begin
			flags <= 3'b000;
		end else begin
			// A new request in the serving clock stays pending
			flags <= (served ? 3'b000 : flags) | {panel_load, panel_fetch, panel_store};
		end
	end

	assign panel_req = |flags;

	// Flags are shown only inside the panel cycle
	assign laduj   = flags[2] & in_panel;
	assign k2fetch = flags[1] & in_panel;
	assign k2store = flags[0] & in_panel;

endmodule : panel_regs

// File: source/pm_pkg.sv
// P-M control definitions

package pm_pkg;

	// Strobe sequencer phases, one clock each
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_S1,
		PH_S1B,
		PH_S2,
		PH_S2B
	} phase_t;

	// Kind of the cycle in progress
	typedef enum logic [1:0] {
		CK_NONE,
		CK_PANEL,
		CK_IRQ,
		CK_FETCH
	} cycle_kind_t;

	// Premodification count where mc_3 comes up
	localparam int unsigned MC_LAST = 3;

	// Group counter width
	localparam int unsigned LG_W = 2;

	// Step counter width, matches the shift count field
	localparam int unsigned LK_W = 4;

endpackage : pm_pkg

// File: source/pm_strobe_if.sv
// Phase strobe bundle
`timescale 1ns/1ps

interface pm_strobe_if;

	logic strob1;
	logic strob1b;
	logic strob2;
	logic strob2b;
	// Cycle start, coincides with strob1
	logic pc;

	modport gen (
		output strob1, strob1b, strob2, strob2b, pc
	);

	modport user (
		input strob1, strob1b, strob2, strob2b, pc
	);

endinterface : pm_strobe_if

// File: source/pm_top.sv
// P-M cycle control top level
`timescale 1ns/1ps

module pm_top
	import pm_pkg::*;
(
	input  logic            clk_sys,
	input  logic            M95_10,
	input  logic            start,
	input  logic            stop,
	input  logic            clo,
	input  logic            hlt,
	input  logic            cycle,
	input  logic            irq,
	input  logic            panel_store,
	input  logic            panel_fetch,
	input  logic            panel_load,
	input  logic            md,
	input  logic            gr,
	input  logic [2:0]      ir_grp,
	input  logic [LK_W-1:0] shift_cnt,
	output logic            run,
	output logic            waiting,
	output logic            sp0,
	output logic            sp1,
	output logic            si1,
	output logic            laduj,
	output logic            k2fetch,
	output logic            k2store,
	output logic            mc_0,
	output logic            mc_3,
	output logic [LG_W-1:0] lg,
	output logic [LK_W-1:0] lk,
	output logic            lk_zero
);

	logic        go;
	logic        panel_req;
	cycle_kind_t kind;

	pm_strobe_if stb_if ();

	strobe_gen i_strobe_gen (
		.clk_sys (clk_sys),
		.M95_10  (M95_10),
		.go      (go),
		.stb     (stb_if.gen)
	);

	run_ctl i_run_ctl (
		.clk_sys   (clk_sys),
		.M95_10    (M95_10),
		.start     (start),
		.stop      (stop),
		.clo       (clo),
		.hlt       (hlt),
		.cycle     (cycle),
		.irq       (irq),
		.mc_0      (mc_0),
		.panel_req (panel_req),
		.stb       (stb_if.user),
		.go        (go),
		.kind      (kind),
		.run       (run),
		.waiting   (waiting),
		.sp0       (sp0),
		.sp1       (sp1),
		.si1       (si1)
	);

	panel_regs i_panel_regs (
		.clk_sys     (clk_sys),
		.M95_10      (M95_10),
		.clo         (clo),
		.panel_store (panel_store),
		.panel_fetch (panel_fetch),
		.panel_load  (panel_load),
		.kind        (kind),
		.stb         (stb_if.user),
		.panel_req   (panel_req),
		.laduj       (laduj),
		.k2fetch     (k2fetch),
		.k2store     (k2store)
	);

	seq_counters i_seq_counters (
		.clk_sys   (clk_sys),
		.M95_10    (M95_10),
		.md        (md),
		.gr        (gr),
		.ir_grp    (ir_grp),
		.shift_cnt (shift_cnt),
		.kind      (kind),
		.stb       (stb_if.user),
		.mc_0      (mc_0),
		.mc_3      (mc_3),
		.lg        (lg),
		.lk        (lk),
		.lk_zero   (lk_zero)
	);

endmodule : pm_top

// File: source/run_ctl.sv
// Run control and cycle-start decision
`timescale 1ns/1ps

module run_ctl
	import pm_pkg::*;
(
	input  logic        clk_sys,
	input  logic        M95_10,
	input  logic        start,
	input  logic        stop,
	input  logic        clo,
	input  logic        hlt,
	input  logic        cycle,
	input  logic        irq,
	input  logic        mc_0,
	input  logic        panel_req,
	pm_strobe_if.user   stb,
	output logic        go,
	output cycle_kind_t kind,
	output logic        run,
	output logic        waiting,
	output logic        sp0,
	output logic        sp1,
	output logic        si1
);

	logic        started;
	logic        hlt_pend;
	logic        single;
	logic        boundary;
	cycle_kind_t kind_next;

	// Start flop, dropped by stop or clear
	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			started <= 1'b0;
		end else if (stop || clo) begin
			started <= 1'b0;
		end else if (start) begin
			started <= 1'b1;
		end
	end

	// Halt request waits for strob2 before it takes effect
	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			hlt_pend <= 1'b0;
			waiting  <= 1'b0;
		end else begin
			if (stop || clo) hlt_pend <= 1'b0;
			else if (hlt) hlt_pend <= 1'b1;
			else if (stb.strob2) hlt_pend <= 1'b0;

			if (stop || clo || si1) waiting <= 1'b0;
			else if (hlt_pend && stb.strob2) waiting <= 1'b1;
		end
	end

	// Single-cycle request, served by one strob2
	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			single <= 1'b0;
		end else if (cycle) begin
			single <= 1'b1;
		end else if (stb.strob2) begin
			single <= 1'b0;
		end
	end

	assign run = started & ~waiting;

	// Fixed priority: panel, then interrupt, then fetch
	always_comb begin
		if (panel_req && !started) kind_next = CK_PANEL;
		else if (irq && started && mc_0) kind_next = CK_IRQ;
		else if (run || single) kind_next = CK_FETCH;
		else kind_next = CK_NONE;
	end

	assign go = (kind_next != CK_NONE);

	// Idle or last phase, where the generator decides on a new cycle
	assign boundary = stb.strob2b |
		~(stb.strob1 | stb.strob1b | stb.strob2 | stb.strob2b);

	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			kind <= CK_NONE;
		end else if (boundary) begin
			kind <= kind_next;
		end
	end

	assign sp0 = stb.pc & (kind == CK_PANEL);
	assign sp1 = stb.pc & (kind == CK_FETCH);
	assign si1 = stb.pc & (kind == CK_IRQ);

endmodule : run_ctl

// File: source/seq_counters.sv
// MC, LG and LK counters
`timescale 1ns/1ps

module seq_counters
	import pm_pkg::*;
(
	input  logic            clk_sys,
	input  logic            M95_10,
	input  logic            md,
	input  logic            gr,
	input  logic [2:0]      ir_grp,
	input  logic [LK_W-1:0] shift_cnt,
	input  cycle_kind_t     kind,
	pm_strobe_if.user       stb,
	output logic            mc_0,
	output logic            mc_3,
	output logic [LG_W-1:0] lg,
	output logic [LK_W-1:0] lk,
	output logic            lk_zero
);

	logic [1:0] mc;
	logic       fetch;
	logic       irq_cyc;

	assign fetch   = (kind == CK_FETCH);
	assign irq_cyc = (kind == CK_IRQ);

	// Premodification counter, saturating at MC_LAST
	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			mc <= '0;
		end else if (irq_cyc) begin
			mc <= '0;
		end else if (fetch && stb.strob1 && md && (mc != 2'(MC_LAST))) begin
			mc <= mc + 2'd1;
		end else if (fetch && stb.strob2 && !md) begin
			mc <= '0;
		end
	end

	assign mc_0 = (mc == '0);
	assign mc_3 = (mc == 2'(MC_LAST));

	// Group counter, strob1b comes before the load at strob2
	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			lg <= '0;
		end else if (fetch && stb.strob2 && gr) begin
			lg <= ir_grp[LG_W-1:0];
		end else if (stb.strob1b && gr) begin
			lg <= lg + 1'b1;
		end
	end

	// Step counter, counts down once per cycle until zero
	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			lk <= '0;
		end else if (fetch && stb.strob2) begin
			lk <= shift_cnt;
		end else if (stb.strob1 && !lk_zero) begin
			lk <= lk - 1'b1;
		end
	end

	assign lk_zero = (lk == '0);

endmodule : seq_counters

// File: source/strobe_gen.sv
// Four-phase strobe sequencer
`timescale 1ns/1ps

module strobe_gen
	import pm_pkg::*;
(
	input  logic        clk_sys,
	input  logic        M95_10,
	input  logic        go,
	pm_strobe_if.gen    stb
);

	phase_t phase;
	phase_t phase_next;

	always_comb begin
		phase_next = phase;
		case (phase)
			PH_IDLE: if (go) phase_next = PH_S1;
			PH_S1:   phase_next = PH_S1B;
			PH_S1B:  phase_next = PH_S2;
			PH_S2:   phase_next = PH_S2B;
			// Back-to-back cycles skip the idle phase
			PH_S2B:  phase_next = go ? PH_S1 : PH_IDLE;
			default: phase_next = PH_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge M95_10) begin
		if (!M95_10) begin
			phase <= PH_IDLE;
		end else begin
			phase <= phase_next;
		end
	end

	// One strobe per phase
	assign stb.strob1  = (phase == PH_S1);
	assign stb.strob1b = (phase == PH_S1B);
	assign stb.strob2  = (phase == PH_S2);
	assign stb.strob2b = (phase == PH_S2B);
	assign stb.pc      = (phase == PH_S1);

endmodule : strobe_gen
